//--- test/decode_execute_tests.txt
// stimulus fields wb_en wb_reg wb_data instr pc stall nop
// expected fields result rd reg_write mem_read mem_write branch_taken branch_target halt
1_1_0005_0000_0000_0_0_0000_0_0_0_0_0_0002_0
1_2_0003_0000_0000_0_0_0000_0_0_0_0_0_0002_0
1_3_1234_D94C_0010_0_0_0008_3_1_0_0_0_0012_0
1_5_00FF_D951_0012_0_0_FFFE_4_1_0_0_0_0014_0
0_0_0000_DB36_0014_0_0_1231_5_1_0_0_0_0016_0
0_0_0000_DBBB_0016_0_0_1200_6_1_0_0_0_0018_0
0_0_0000_415D_0020_0_0_0002_2_1_0_0_0_001F_0
0_0_0000_4970_0022_0_0_FFEB_3_1_0_0_0_0014_0
0_0_0000_539F_0024_0_0_122B_4_1_0_0_0_0045_0
0_0_0000_5D35_0026_0_0_00EA_1_1_0_0_0_003D_0
0_0_0000_C69A_0030_0_0_FF9A_6_1_0_0_0_FFCC_0
0_0_0000_8B44_0032_0_0_1238_2_1_1_0_0_0038_0
0_0_0000_81BE_0034_0_0_0003_5_0_0_1_0_0034_0
0_0_0000_3008_0040_0_0_0042_7_1_0_0_0_004A_0
0_0_0000_0800_0042_0_0_0000_0_0_0_0_0_0044_1
0_0_0000_6410_0050_0_0_0010_0_0_0_0_1_0062_0
0_0_0000_61F8_0052_0_0_FFFD_7_0_0_0_0_004C_0
0_0_0000_6904_0054_0_0_0009_0_0_0_0_1_005A_0
0_0_0000_6C7F_0056_0_0_007F_3_0_0_0_0_00D7_0
0_0_0000_D94C_0060_0_0_0008_3_1_0_0_0_0062_0
0_0_0000_0800_0070_1_0_0008_3_1_0_0_0_0062_0
0_0_0000_0800_0070_0_1_0000_0_0_0_0_0_0072_0
1_4_0040_8B44_0072_0_1_1238_2_0_0_0_0_0078_0
0_0_0000_6410_0080_0_0_0050_0_0_0_0_0_0092_0

//--- verilog.f
+incdir+include
hw/cpu_pkg.sv
hw/reg_file.sv
hw/instr_decode.sv
hw/id_ex.sv
hw/alu_exec.sv
hw/decode_execute.sv
test/decode_execute_chk.sv
test/decode_execute_tb.sv

//--- test/decode_execute_tb.sv
`timescale 1ns/1ps

module decode_execute_tb;

  import cpu_pkg::*;

  localparam int NUM_TESTS  = 24;
  // one cycle per line plus room for reset
  localparam int MAX_CYCLES = NUM_TESTS + 20;

  logic         clk;
  logic         rst_n;
  word_t        instr;
  word_t        pc;
  logic         stall;
  logic         nop;
  logic         wb_en;
  reg_idx_t     wb_reg;
  word_t        wb_data;
  word_t        ex_result;
  reg_idx_t     ex_rd;
  logic         ex_reg_write;
  logic         ex_mem_read;
  logic         ex_mem_write;
  logic         ex_mem_to_reg;
  logic         ex_branch_taken;
  word_t        ex_branch_target;
  logic         ex_halt;
  logic         ex_stalled;

  logic [119:0] tests [NUM_TESTS];
  logic [119:0] vec;
  int           step;
  int           cycles;

  decode_execute u_decode_execute (.*);

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: step %0d, %s is %h, expected %h",
               $time, step, name, got, exp);
      $display("Simulation FAILED");
      $fatal(1, "%s mismatch", name);
    end
  endtask

  task automatic check_reg(input string name, input reg_idx_t got, input reg_idx_t exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: step %0d, %s is %0d, expected %0d",
               $time, step, name, got, exp);
      $display("Simulation FAILED");
      $fatal(1, "%s mismatch", name);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: step %0d, %s is %b, expected %b",
               $time, step, name, got, exp);
      $display("Simulation FAILED");
      $fatal(1, "%s mismatch", name);
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout, the test lines did not finish within %0d cycles", MAX_CYCLES);
    $display("Simulation FAILED");
    $fatal(1, "timeout");
  end

  initial begin
    wait (u_decode_execute.u_chk.fail_count != 0);
    $display("the bound checker reported an assertion failure at %0t ns", $time);
    $display("Simulation FAILED");
    $fatal(1, "assertion failure");
  end

  initial begin
    rst_n   = 1'b0;
    instr   = '0;
    pc      = '0;
    stall   = 1'b0;
    nop     = 1'b0;
    wb_en   = 1'b0;
    wb_reg  = '0;
    wb_data = '0;
    step    = -1;
    $readmemh("test/decode_execute_tests.txt", tests);
    if ($isunknown(tests[NUM_TESTS-1])) begin
      $display("the test file is missing or has fewer than %0d lines", NUM_TESTS);
      $display("Simulation FAILED");
      $fatal(1, "no test lines");
    end
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    // nothing captured yet, so every control output is still idle
    check_flag("ex_reg_write", ex_reg_write, 1'b0);
    check_flag("ex_mem_read", ex_mem_read, 1'b0);
    check_flag("ex_mem_write", ex_mem_write, 1'b0);
    check_flag("ex_branch_taken", ex_branch_taken, 1'b0);
    check_flag("ex_halt", ex_halt, 1'b0);
    check_flag("ex_stalled", ex_stalled, 1'b0);
    for (int i = 0; i < NUM_TESTS; i++) begin
      step    = i;
      vec     = tests[i];
      wb_en   = vec[116];
      wb_reg  = vec[114:112];
      wb_data = vec[111:96];
      instr   = vec[95:80];
      pc      = vec[79:64];
      stall   = vec[60];
      nop     = vec[56];
      @(negedge clk);
      check_word("ex_result", ex_result, vec[55:40]);
      check_reg("ex_rd", ex_rd, vec[38:36]);
      check_flag("ex_reg_write", ex_reg_write, vec[32]);
      check_flag("ex_mem_read", ex_mem_read, vec[28]);
      // only a load routes memory to the register
      check_flag("ex_mem_to_reg", ex_mem_to_reg, vec[28]);
      check_flag("ex_mem_write", ex_mem_write, vec[24]);
      check_flag("ex_branch_taken", ex_branch_taken, vec[20]);
      check_word("ex_branch_target", ex_branch_target, vec[19:4]);
      check_flag("ex_halt", ex_halt, vec[0]);
      check_flag("ex_stalled", ex_stalled, vec[60]);
    end
    if (u_decode_execute.u_chk.fail_count == 0) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      $display("%0d assertion failures were reported by the checker",
               u_decode_execute.u_chk.fail_count);
      $display("Simulation FAILED");
      $fatal(1, "assertion failures");
    end
  end

endmodule

//--- test/decode_execute_chk.sv
`timescale 1ns/1ps

module decode_execute_chk (
  input logic              clk,
  input logic              rst_n,
  input logic              stall,
  input logic              nop_x,
  input cpu_pkg::word_t    ex_result,
  input cpu_pkg::reg_idx_t ex_rd,
  input logic              ex_reg_write,
  input logic              ex_mem_read,
  input logic              ex_mem_write,
  input logic              ex_branch_taken,
  input logic              ex_halt,
  input logic              ex_stalled
);

  int fail_count = 0;

  reset_idle: assert property (@(posedge clk)
    !rst_n |-> !(ex_reg_write || ex_mem_read || ex_mem_write || ex_branch_taken
                 || ex_halt || ex_stalled))
    else begin
      $error("control outputs active during reset");
      fail_count++;
    end

  // a stalled edge recirculates the stage
  stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
    $past(stall) |-> $stable(ex_result) && $stable(ex_rd))
    else begin
      $error("execute result changed across a stall");
      fail_count++;
    end

  nop_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    nop_x |-> !ex_reg_write && !ex_mem_write)
    else begin
      $error("squashed instruction still writes");
      fail_count++;
    end

endmodule

bind decode_execute decode_execute_chk u_chk (
  .clk(clk), .rst_n(rst_n), .stall(stall), .nop_x(nop_x),
  .ex_result(ex_result), .ex_rd(ex_rd), .ex_reg_write(ex_reg_write),
  .ex_mem_read(ex_mem_read), .ex_mem_write(ex_mem_write),
  .ex_branch_taken(ex_branch_taken), .ex_halt(ex_halt), .ex_stalled(ex_stalled)
);

//--- hw/decode_execute.sv
`timescale 1ns/1ps

module decode_execute (
  input  logic              clk,
  input  logic              rst_n,
  input  cpu_pkg::word_t    instr,
  input  cpu_pkg::word_t    pc,
  input  logic              stall,
  input  logic              nop,
  input  logic              wb_en,
  input  cpu_pkg::reg_idx_t wb_reg,
  input  cpu_pkg::word_t    wb_data,
  output cpu_pkg::word_t    ex_result,
  output cpu_pkg::reg_idx_t ex_rd,
  output logic              ex_reg_write,
  output logic              ex_mem_read,
  output logic              ex_mem_write,
  output logic              ex_mem_to_reg,
  output logic              ex_branch_taken,
  output cpu_pkg::word_t    ex_branch_target,
  output logic              ex_halt,
  output logic              ex_stalled
);

  import cpu_pkg::*;

  reg_idx_t    rs_idx, rt_idx;
  word_t       rs_data_d, rt_data_d, imm_d;
  opcode_t     opcode_d;
  func_t       func_d;
  result_sel_t result_sel_d;
  reg_idx_t    rd_d;
  logic        reg_write_d, mem_read_d, mem_write_d, mem_to_reg_d;
  logic        branch_d, save_pc_d, halt_d;

  word_t       rs_data_x, rt_data_x, imm_x, pc_x;
  opcode_t     opcode_x;
  func_t       func_x;
  result_sel_t result_sel_x;
  reg_idx_t    rd_x;
  logic        reg_write_x, mem_read_x, mem_write_x, mem_to_reg_x;
  logic        branch_x, save_pc_x, halt_x, nop_x;

  // write port stands in for write-back
  reg_file u_reg_file (
    .clk(clk), .rst_n(rst_n),
    .rd_addr_a(rs_idx), .rd_addr_b(rt_idx),
    .rd_data_a(rs_data_d), .rd_data_b(rt_data_d),
    .wr_en(wb_en), .wr_addr(wb_reg), .wr_data(wb_data)
  );

  instr_decode u_instr_decode (
    .instr(instr), .rs(rs_idx), .rt(rt_idx), .rd(rd_d), .imm(imm_d),
    .opcode(opcode_d), .func(func_d), .result_sel(result_sel_d),
    .reg_write(reg_write_d), .mem_read(mem_read_d), .mem_write(mem_write_d),
    .mem_to_reg(mem_to_reg_d), .branch(branch_d), .save_pc(save_pc_d), .halt(halt_d)
  );

  id_ex u_id_ex (
    .clk(clk), .rst_n(rst_n), .stall_d(stall), .nop_d(nop),
    .rs_data_d(rs_data_d), .rt_data_d(rt_data_d), .imm_d(imm_d), .pc_d(pc),
    .opcode_d(opcode_d), .func_d(func_d), .result_sel_d(result_sel_d), .rd_d(rd_d),
    .reg_write_d(reg_write_d), .mem_read_d(mem_read_d), .mem_write_d(mem_write_d),
    .mem_to_reg_d(mem_to_reg_d), .branch_d(branch_d), .save_pc_d(save_pc_d),
    .halt_d(halt_d),
    .rs_data_x(rs_data_x), .rt_data_x(rt_data_x), .imm_x(imm_x), .pc_x(pc_x),
    .opcode_x(opcode_x), .func_x(func_x), .result_sel_x(result_sel_x), .rd_x(rd_x),
    .reg_write_x(reg_write_x), .mem_read_x(mem_read_x), .mem_write_x(mem_write_x),
    .mem_to_reg_x(mem_to_reg_x), .branch_x(branch_x), .save_pc_x(save_pc_x),
    .halt_x(halt_x), .nop_x(nop_x), .stall_x(ex_stalled)
  );

  alu_exec u_alu_exec (
    .rs_data(rs_data_x), .rt_data(rt_data_x), .imm(imm_x), .pc(pc_x),
    .opcode(opcode_x), .func(func_x), .result_sel(result_sel_x), .rd(rd_x),
    .reg_write(reg_write_x), .mem_read(mem_read_x), .mem_write(mem_write_x),
    .mem_to_reg(mem_to_reg_x), .branch(branch_x), .save_pc(save_pc_x),
    .halt(halt_x), .nop(nop_x),
    .result(ex_result), .rd_out(ex_rd), .reg_write_out(ex_reg_write),
    .mem_read_out(ex_mem_read), .mem_write_out(ex_mem_write),
    .mem_to_reg_out(ex_mem_to_reg), .branch_taken(ex_branch_taken),
    .branch_target(ex_branch_target), .halt_out(ex_halt)
  );

endmodule

//--- hw/alu_exec.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module alu_exec (
  input  cpu_pkg::word_t       rs_data,
  input  cpu_pkg::word_t       rt_data,
  input  cpu_pkg::word_t       imm,
  input  cpu_pkg::word_t       pc,
  input  cpu_pkg::opcode_t     opcode,
  input  cpu_pkg::func_t       func,
  input  cpu_pkg::result_sel_t result_sel,
  input  cpu_pkg::reg_idx_t    rd,
  input  logic                 reg_write, mem_read, mem_write, mem_to_reg,
  input  logic                 branch, save_pc, halt, nop,
  output cpu_pkg::word_t       result,
  output cpu_pkg::reg_idx_t    rd_out,
  output logic                 reg_write_out, mem_read_out, mem_write_out, mem_to_reg_out,
  output logic                 branch_taken,
  output cpu_pkg::word_t       branch_target,
  output logic                 halt_out
);

  import cpu_pkg::*;

  word_t pc_plus2;
  word_t op_b;
  word_t alu_out;
  func_t alu_func;
  logic  is_mem;
  logic  rs_zero;
  logic  take;

  assign pc_plus2 = pc + word_t'(2);
  assign is_mem   = (opcode == `OP_LD) || (opcode == `OP_ST);
  assign op_b     = (opcode == `OP_ALU) ? rt_data : imm;
  // address generation always adds
  assign alu_func = is_mem ? `FUNC_ADD : func;

  always_comb begin
    case (alu_func)
      `FUNC_ADD: alu_out = rs_data + op_b;
      `FUNC_SUB: alu_out = op_b - rs_data;
      `FUNC_XOR: alu_out = rs_data ^ op_b;
      default:   alu_out = rs_data & ~op_b;
    endcase
  end

  always_comb begin
    case (result_sel)
      `SEL_IMM: result = imm;
      `SEL_PC2: result = pc_plus2;
      default:  result = alu_out;
    endcase
  end

  assign rs_zero = (rs_data == '0);
  assign take    = branch && ((opcode == `OP_BEQZ) ? rs_zero : !rs_zero);

  assign branch_target = pc_plus2 + imm;
  // link register for jal
  assign rd_out = save_pc ? reg_idx_t'(`CPU_REG_N - 1) : rd;

  // a squashed instruction must not change any state
  assign reg_write_out  = reg_write && !nop;
  assign mem_read_out   = mem_read && !nop;
  assign mem_write_out  = mem_write && !nop;
  assign mem_to_reg_out = mem_to_reg && !nop;
  assign branch_taken   = take && !nop;
  assign halt_out       = halt && !nop;

endmodule

//--- hw/id_ex.sv
`timescale 1ns/1ps

module id_ex (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 stall_d,
  input  logic                 nop_d,
  input  cpu_pkg::word_t       rs_data_d, rt_data_d, imm_d, pc_d,
  input  cpu_pkg::opcode_t     opcode_d,
  input  cpu_pkg::func_t       func_d,
  input  cpu_pkg::result_sel_t result_sel_d,
  input  cpu_pkg::reg_idx_t    rd_d,
  input  logic                 reg_write_d, mem_read_d, mem_write_d, mem_to_reg_d,
  input  logic                 branch_d, save_pc_d, halt_d,
  output cpu_pkg::word_t       rs_data_x, rt_data_x, imm_x, pc_x,
  output cpu_pkg::opcode_t     opcode_x,
  output cpu_pkg::func_t       func_x,
  output cpu_pkg::result_sel_t result_sel_x,
  output cpu_pkg::reg_idx_t    rd_x,
  output logic                 reg_write_x, mem_read_x, mem_write_x, mem_to_reg_x,
  output logic                 branch_x, save_pc_x, halt_x,
  output logic                 nop_x,
  output logic                 stall_x
);

  import cpu_pkg::*;

  localparam int STAGE_W = 4 * $bits(word_t) + $bits(opcode_t) + $bits(func_t)
                         + $bits(result_sel_t) + $bits(reg_idx_t) + 7;

  logic [STAGE_W-1:0] stage_d;
  logic [STAGE_W-1:0] stage_next;
  logic [STAGE_W-1:0] stage_q;

  assign stage_d = {rs_data_d, rt_data_d, imm_d, pc_d, opcode_d, func_d, result_sel_d,
                    rd_d, reg_write_d, mem_read_d, mem_write_d, mem_to_reg_d,
                    branch_d, save_pc_d, halt_d};

  // stall recirculates the current contents
  assign stage_next = stall_d ? stage_q : stage_d;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stage_q <= '0;
      nop_x   <= 1'b0;
      stall_x <= 1'b0;
    end else begin
      stage_q <= stage_next;
      nop_x   <= nop_d;
      stall_x <= stall_d;
    end
  end

  assign {rs_data_x, rt_data_x, imm_x, pc_x, opcode_x, func_x, result_sel_x,
          rd_x, reg_write_x, mem_read_x, mem_write_x, mem_to_reg_x,
          branch_x, save_pc_x, halt_x} = stage_q;

endmodule

//--- hw/instr_decode.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module instr_decode (
  input  cpu_pkg::word_t       instr,
  output cpu_pkg::reg_idx_t    rs,
  output cpu_pkg::reg_idx_t    rt,
  output cpu_pkg::reg_idx_t    rd,
  output cpu_pkg::word_t       imm,
  output cpu_pkg::opcode_t     opcode,
  output cpu_pkg::func_t       func,
  output cpu_pkg::result_sel_t result_sel,
  output logic                 reg_write,
  output logic                 mem_read,
  output logic                 mem_write,
  output logic                 mem_to_reg,
  output logic                 branch,
  output logic                 save_pc,
  output logic                 halt
);

  import cpu_pkg::*;

  word_t sext5;
  word_t zext5;
  word_t sext8;
  word_t sext11;

  assign opcode = opcode_t'(instr[15:11]);
  assign rs     = instr[10:8];
  assign rt     = instr[7:5];

  // candidate immediates
  assign sext5  = {{(`CPU_DATA_W-5){instr[4]}}, instr[4:0]};
  assign zext5  = {{(`CPU_DATA_W-5){1'b0}}, instr[4:0]};
  assign sext8  = {{(`CPU_DATA_W-8){instr[7]}}, instr[7:0]};
  assign sext11 = {{(`CPU_DATA_W-11){instr[10]}}, instr[10:0]};

  always_comb begin
    rd         = instr[7:5];
    imm        = '0;
    func       = `FUNC_ADD;
    result_sel = `SEL_ALU;
    reg_write  = 1'b0;
    mem_read   = 1'b0;
    mem_write  = 1'b0;
    mem_to_reg = 1'b0;
    branch     = 1'b0;
    save_pc    = 1'b0;
    halt       = 1'b0;
    case (opcode)
      `OP_ALU: begin
        rd        = instr[4:2];
        func      = instr[1:0];
        reg_write = 1'b1;
      end
      `OP_ADDI, `OP_SUBI: begin
        imm       = sext5;
        func      = opcode[1:0];
        reg_write = 1'b1;
      end
      `OP_XORI, `OP_ANDNI: begin
        imm       = zext5;
        func      = opcode[1:0];
        reg_write = 1'b1;
      end
      `OP_LBI: begin
        // lbi loads into the rs field
        rd         = instr[10:8];
        imm        = sext8;
        result_sel = `SEL_IMM;
        reg_write  = 1'b1;
      end
      `OP_LD: begin
        imm        = sext5;
        mem_read   = 1'b1;
        mem_to_reg = 1'b1;
        reg_write  = 1'b1;
      end
      `OP_ST: begin
        imm       = sext5;
        mem_write = 1'b1;
      end
      `OP_BEQZ, `OP_BNEZ: begin
        imm    = sext8;
        branch = 1'b1;
      end
      `OP_JAL: begin
        rd         = reg_idx_t'(`CPU_REG_N - 1);
        imm        = sext11;
        result_sel = `SEL_PC2;
        save_pc    = 1'b1;
        reg_write  = 1'b1;
      end
      `OP_HALT: halt = 1'b1;
      // OP_NOP and anything unknown leave all controls off
      default: ;
    endcase
  end

endmodule

//--- hw/reg_file.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module reg_file (
  input  logic             clk,
  input  logic             rst_n,
  input  cpu_pkg::reg_idx_t rd_addr_a,
  input  cpu_pkg::reg_idx_t rd_addr_b,
  output cpu_pkg::word_t   rd_data_a,
  output cpu_pkg::word_t   rd_data_b,
  input  logic             wr_en,
  input  cpu_pkg::reg_idx_t wr_addr,
  input  cpu_pkg::word_t   wr_data
);

  import cpu_pkg::*;

  word_t regs [`CPU_REG_N];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `CPU_REG_N; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // no write bypass, a write shows up after the edge
  assign rd_data_a = regs[rd_addr_a];
  assign rd_data_b = regs[rd_addr_b];

endmodule

//--- hw/cpu_pkg.sv
`include "cpu_consts.svh"

package cpu_pkg;

  // data word, also used for pc and immediates
  typedef logic [`CPU_DATA_W-1:0] word_t;

  typedef logic [`CPU_REG_IDX_W-1:0] reg_idx_t;

  typedef logic [`CPU_OPCODE_W-1:0] opcode_t;

  typedef logic [`CPU_FUNC_W-1:0] func_t;

  // result source in execute
  typedef logic [`CPU_SEL_W-1:0] result_sel_t;

endpackage

//--- include/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// datapath sizes
`define CPU_DATA_W     16
`define CPU_REG_N      8
`define CPU_REG_IDX_W  3
`define CPU_OPCODE_W   5
`define CPU_FUNC_W     2
`define CPU_SEL_W      2

// opcodes, 0 doubles as the reset nop
`define OP_NOP    5'b00000
`define OP_HALT   5'b00001
`define OP_JAL    5'b00110
`define OP_ADDI   5'b01000
`define OP_SUBI   5'b01001
`define OP_XORI   5'b01010
`define OP_ANDNI  5'b01011
`define OP_BEQZ   5'b01100
`define OP_BNEZ   5'b01101
`define OP_ST     5'b10000
`define OP_LD     5'b10001
`define OP_LBI    5'b11000
`define OP_ALU    5'b11011

// immediate alu opcodes carry these in their low two bits
`define FUNC_ADD  2'b00
`define FUNC_SUB  2'b01
`define FUNC_XOR  2'b10
`define FUNC_ANDN 2'b11

`define SEL_ALU   2'd0
`define SEL_IMM   2'd1
`define SEL_PC2   2'd2

`endif
